//--- rtl/branch_macros.svh
// Global sizing constants for the branch execution path
// Included by the package and by any module that sizes its own vectors

`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// Data path width
`define XLEN 32

// Width of a reorder-buffer tag
`define ROB_IDX_LEN 4

// Branch reservation station entries, power of two only
`define BRANCH_RS_DEPTH 4

`endif

//--- rtl/branch_pkg.sv
// Shared types of the branch path: opcodes, arbiter state and the
// packed records that travel between issue, branch unit and CDB

`include "branch_macros.svh"

package branch_pkg;

    // Branch and jump opcodes
    typedef enum logic [2:0] {
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } branch_op_e;

    // Requester favoured by the CDB arbiter on the next conflict
    typedef enum logic {
        PRIO_BRANCH,
        PRIO_EXT
    } arb_state_e;

    typedef logic [`ROB_IDX_LEN-1:0] rob_idx_t;

    // Instruction as handed over by the issue stage
    typedef struct packed {
        branch_op_e         op;
        logic               rs1_ready;      // rs1_value valid, else wait on rs1_idx
        rob_idx_t           rs1_idx;
        logic [`XLEN-1:0]   rs1_value;
        logic               rs2_ready;
        rob_idx_t           rs2_idx;
        logic [`XLEN-1:0]   rs2_value;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   pred_target;    // From the fetch predictor
        logic               pred_taken;
        rob_idx_t           dest_idx;       // ROB slot of this branch
    } branch_issue_t;

    // Operands sent to the branch unit
    typedef struct packed {
        branch_op_e         op;
        logic [`XLEN-1:0]   rs1;
        logic [`XLEN-1:0]   rs2;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   pred_target;
        logic               pred_taken;
    } branch_exec_t;

    // One CDB broadcast
    typedef struct packed {
        rob_idx_t           rob_idx;
        logic [`XLEN-1:0]   value;
        logic               except_raised;
    } cdb_data_t;

endpackage

//--- rtl/branch_unit.sv
// Single-stage branch unit. Resolves direction and target, compares them
// with the prediction and returns a registered mispredict flag

`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_unit (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    input  logic                        ex_valid_i,
    input  branch_pkg::branch_exec_t    ex_data_i,
    output logic                        ex_ready_o,
    output logic                        res_valid_o,
    output logic                        res_mispredict_o
);
    import branch_pkg::*;

    logic               accept;
    logic               taken;
    logic               mispredict;
    logic [`XLEN-1:0]   base, sum, target;

    // One stage and no back-pressure on the result
    assign ex_ready_o = 1'b1;
    assign accept     = ex_valid_i && ex_ready_o;

    // Branch condition
    always_comb begin
        unique case (ex_data_i.op)
            BEQ:  taken = (ex_data_i.rs1 == ex_data_i.rs2);
            BNE:  taken = (ex_data_i.rs1 != ex_data_i.rs2);
            BLT:  taken = ($signed(ex_data_i.rs1) <  $signed(ex_data_i.rs2));
            BGE:  taken = ($signed(ex_data_i.rs1) >= $signed(ex_data_i.rs2));
            BLTU: taken = (ex_data_i.rs1 <  ex_data_i.rs2);
            BGEU: taken = (ex_data_i.rs1 >= ex_data_i.rs2);
            JAL:  taken = 1'b1;
            JALR: taken = 1'b1;
        endcase
    end

    // Target, JALR is register relative with bit 0 dropped
    assign base   = (ex_data_i.op == JALR) ? ex_data_i.rs1 : ex_data_i.pc;
    assign sum    = base + ex_data_i.imm;
    assign target = (ex_data_i.op == JALR) ? {sum[`XLEN-1:1], 1'b0} : sum;

    // Wrong direction, or right direction to the wrong place
    assign mispredict = (taken != ex_data_i.pred_taken)
                        || (taken && (target != ex_data_i.pred_target));

    // --------------------------------------------------------------------------
    // Result register
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            res_valid_o <= 1'b0;        // Drop the result in flight
        end else begin
            res_valid_o <= accept;      // High for one cycle per dispatch
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) res_mispredict_o <= mispredict;
    end

endmodule

//--- rtl/cdb_arbiter.sv
// Two-way round-robin CDB arbiter between the branch station and an
// external result producer. Grant is locked while the CDB stalls

`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // Branch reservation station
    input  logic                    br_valid_i,
    input  branch_pkg::cdb_data_t   br_data_i,
    output logic                    br_ready_o,
    // External producer
    input  logic                    ext_valid_i,
    input  branch_pkg::cdb_data_t   ext_data_i,
    output logic                    ext_ready_o,
    // CDB
    output logic                    cdb_valid_o,
    output branch_pkg::cdb_data_t   cdb_data_o,
    input  logic                    cdb_ready_i
);
    import branch_pkg::*;

    arb_state_e prio_q;
    logic       stall_q;        // Last cycle offered a transfer that was not taken
    logic       held_ext_q;     // Side granted during that stall
    logic       sel_ext;

    // Keep the stalled winner, else sole requester or favoured side wins
    assign sel_ext = stall_q ? held_ext_q
                             : (ext_valid_i && (!br_valid_i || (prio_q == PRIO_EXT)));

    assign cdb_valid_o = sel_ext ? ext_valid_i : br_valid_i;
    assign cdb_data_o  = sel_ext ? ext_data_i  : br_data_i;
    assign ext_ready_o = ext_valid_i && sel_ext && cdb_ready_i;
    assign br_ready_o  = br_valid_i && !sel_ext && cdb_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q     <= PRIO_BRANCH;
            stall_q    <= 1'b0;
            held_ext_q <= 1'b0;
        end else begin
            stall_q    <= cdb_valid_o && !cdb_ready_i;
            held_ext_q <= sel_ext;
            if (cdb_valid_o && cdb_ready_i) begin
                prio_q <= sel_ext ? PRIO_BRANCH : PRIO_EXT;   // Favour the loser next
            end
        end
    end

    a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(br_ready_o && ext_ready_o))
        else $error("CDB granted to both requesters");

endmodule

//--- rtl/branch_rs.sv
// Branch reservation station. Circular buffer with in-order issue,
// CDB operand snooping, dispatch to the branch unit and CDB writeback

`timescale 1ns/1ps
`include "branch_macros.svh"

module branch_rs (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    // Issue channel
    input  logic                        issue_valid_i,
    input  branch_pkg::branch_issue_t   issue_i,
    output logic                        issue_ready_o,
    // Dispatch to branch unit
    output logic                        ex_valid_o,
    output branch_pkg::branch_exec_t    ex_data_o,
    input  logic                        ex_ready_i,
    // Result from branch unit, always taken
    input  logic                        res_valid_i,
    input  logic                        res_mispredict_i,
    // Writeback request towards the CDB arbiter
    output logic                        wb_valid_o,
    output branch_pkg::cdb_data_t       wb_data_o,
    input  logic                        wb_ready_i,
    // Accepted CDB transfers
    input  logic                        snoop_valid_i,
    input  branch_pkg::cdb_data_t       snoop_data_i
);
    import branch_pkg::*;

    localparam int RS_IDX_LEN = $clog2(`BRANCH_RS_DEPTH);

    // Control bits of an entry, reset and flushed
    typedef struct packed {
        logic valid;        // Slot allocated
        logic busy;         // In flight in the branch unit
        logic rs1_ready;
        logic rs2_ready;
        logic res_ready;    // Mispredict bit written back
    } rs_status_t;

    // Payload of an entry
    typedef struct packed {
        branch_op_e         op;
        rob_idx_t           rs1_idx;
        logic [`XLEN-1:0]   rs1_value;
        rob_idx_t           rs2_idx;
        logic [`XLEN-1:0]   rs2_value;
        logic [`XLEN-1:0]   imm;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   pred_target;
        logic               pred_taken;
        rob_idx_t           dest_idx;
        logic               mispredict;
    } rs_entry_t;

    rs_status_t                 st_q    [`BRANCH_RS_DEPTH];
    rs_entry_t                  entry_q [`BRANCH_RS_DEPTH];
    logic [RS_IDX_LEN-1:0]      tail_q, ex_q, res_q, head_q;   // Push, dispatch, result, pop
    logic                       push, dispatch, pop;
    logic                       snoop_ok;
    logic                       push_rs1_hit, push_rs2_hit;   // Broadcast during push
    logic [`BRANCH_RS_DEPTH-1:0] rs1_hit, rs2_hit;

    // --------------------------------------------------------------------------
    // Operand snooping
    // --------------------------------------------------------------------------
    assign snoop_ok = snoop_valid_i && !snoop_data_i.except_raised;  // Exceptions carry no operand

    always_comb begin
        for (int i = 0; i < `BRANCH_RS_DEPTH; i++) begin
            rs1_hit[i] = snoop_ok && st_q[i].valid && !st_q[i].rs1_ready
                         && (entry_q[i].rs1_idx == snoop_data_i.rob_idx);
            rs2_hit[i] = snoop_ok && st_q[i].valid && !st_q[i].rs2_ready
                         && (entry_q[i].rs2_idx == snoop_data_i.rob_idx);
        end
    end

    // Catch a producer that broadcasts in the very cycle of the push
    assign push_rs1_hit = snoop_ok && !issue_i.rs1_ready
                          && (issue_i.rs1_idx == snoop_data_i.rob_idx);
    assign push_rs2_hit = snoop_ok && !issue_i.rs2_ready
                          && (issue_i.rs2_idx == snoop_data_i.rob_idx);

    // --------------------------------------------------------------------------
    // Handshakes
    // --------------------------------------------------------------------------
    assign issue_ready_o = !st_q[tail_q].valid;    // Full once tail wraps onto a live slot
    assign push          = issue_valid_i && issue_ready_o;

    assign ex_valid_o = st_q[ex_q].valid && !st_q[ex_q].busy && !st_q[ex_q].res_ready
                        && st_q[ex_q].rs1_ready && st_q[ex_q].rs2_ready;
    assign dispatch   = ex_valid_o && ex_ready_i;

    assign wb_valid_o = st_q[head_q].valid && st_q[head_q].res_ready;
    assign pop        = wb_valid_o && wb_ready_i;

    // Operands of the oldest undispatched entry
    assign ex_data_o.op          = entry_q[ex_q].op;
    assign ex_data_o.rs1         = entry_q[ex_q].rs1_value;
    assign ex_data_o.rs2         = entry_q[ex_q].rs2_value;
    assign ex_data_o.imm         = entry_q[ex_q].imm;
    assign ex_data_o.pc          = entry_q[ex_q].pc;
    assign ex_data_o.pred_target = entry_q[ex_q].pred_target;
    assign ex_data_o.pred_taken  = entry_q[ex_q].pred_taken;

    // Mispredict flag goes out in the LSB of the value field
    assign wb_data_o.rob_idx       = entry_q[head_q].dest_idx;
    assign wb_data_o.value         = {{(`XLEN-1){1'b0}}, entry_q[head_q].mispredict};
    assign wb_data_o.except_raised = 1'b0;

    // --------------------------------------------------------------------------
    // Status bits and pointers
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `BRANCH_RS_DEPTH; i++) st_q[i] <= '0;
            tail_q <= '0;
            ex_q   <= '0;
            res_q  <= '0;
            head_q <= '0;
        end else if (flush_i) begin
            for (int i = 0; i < `BRANCH_RS_DEPTH; i++) st_q[i] <= '0;
            tail_q <= '0;
            ex_q   <= '0;
            res_q  <= '0;
            head_q <= '0;
        end else begin
            for (int i = 0; i < `BRANCH_RS_DEPTH; i++) begin
                if (rs1_hit[i]) st_q[i].rs1_ready <= 1'b1;
                if (rs2_hit[i]) st_q[i].rs2_ready <= 1'b1;
            end
            if (push) begin
                st_q[tail_q].valid     <= 1'b1;
                st_q[tail_q].busy      <= 1'b0;
                st_q[tail_q].rs1_ready <= issue_i.rs1_ready || push_rs1_hit;
                st_q[tail_q].rs2_ready <= issue_i.rs2_ready || push_rs2_hit;
                st_q[tail_q].res_ready <= 1'b0;
                tail_q                 <= tail_q + 1'b1;
            end
            if (dispatch) begin
                st_q[ex_q].busy <= 1'b1;
                ex_q            <= ex_q + 1'b1;
            end
            // Results come back in dispatch order
            if (res_valid_i) begin
                st_q[res_q].busy      <= 1'b0;
                st_q[res_q].res_ready <= 1'b1;
                res_q                 <= res_q + 1'b1;
            end
            if (pop) begin
                st_q[head_q].valid     <= 1'b0;  // Slot free for the next push
                st_q[head_q].res_ready <= 1'b0;
                head_q                 <= head_q + 1'b1;
            end
        end
    end

    // --------------------------------------------------------------------------
    // Entry payload
    // --------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `BRANCH_RS_DEPTH; i++) begin
            if (rs1_hit[i]) entry_q[i].rs1_value <= snoop_data_i.value;
            if (rs2_hit[i]) entry_q[i].rs2_value <= snoop_data_i.value;
        end
        if (push) begin
            entry_q[tail_q].op          <= issue_i.op;
            entry_q[tail_q].rs1_idx     <= issue_i.rs1_idx;
            entry_q[tail_q].rs1_value   <= push_rs1_hit ? snoop_data_i.value : issue_i.rs1_value;
            entry_q[tail_q].rs2_idx     <= issue_i.rs2_idx;
            entry_q[tail_q].rs2_value   <= push_rs2_hit ? snoop_data_i.value : issue_i.rs2_value;
            entry_q[tail_q].imm         <= issue_i.imm;
            entry_q[tail_q].pc          <= issue_i.pc;
            entry_q[tail_q].pred_target <= issue_i.pred_target;
            entry_q[tail_q].pred_taken  <= issue_i.pred_taken;
            entry_q[tail_q].dest_idx    <= issue_i.dest_idx;
        end
        if (res_valid_i) entry_q[res_q].mispredict <= res_mispredict_i;
    end

    // --------------------------------------------------------------------------
    // Assertions
    // --------------------------------------------------------------------------
    for (genvar g = 0; g < `BRANCH_RS_DEPTH; g++) begin : g_res_chk
        // A result only ever lands on an entry that was in the branch unit
        a_res_after_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            $rose(st_q[g].res_ready) |-> $past(st_q[g].busy))
            else $error("RS entry %0d got a result without being busy", g);
    end

    a_res_slot_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_valid_i |-> st_q[res_q].busy)
        else $error("Branch result arrived for an idle RS entry");

endmodule

//--- rtl/branch_exec_top.sv
// Branch execution back end. Reservation station, branch unit and CDB
// arbiter, with every accepted CDB transfer looped back for snooping

`timescale 1ns/1ps

module branch_exec_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,
    // Issue
    input  logic                        issue_valid_i,
    input  branch_pkg::branch_issue_t   issue_i,
    output logic                        issue_ready_o,
    // External result producer
    input  logic                        ext_valid_i,
    input  branch_pkg::cdb_data_t       ext_data_i,
    output logic                        ext_ready_o,
    // CDB
    output logic                        cdb_valid_o,
    output branch_pkg::cdb_data_t       cdb_data_o,
    input  logic                        cdb_ready_i
);
    import branch_pkg::*;

    branch_exec_t   ex_data;
    cdb_data_t      wb_data;
    logic           ex_valid, ex_ready;
    logic           res_valid, res_mispredict;
    logic           wb_valid, wb_ready;
    logic           snoop_valid;

    // Only a completed transfer counts as a broadcast
    assign snoop_valid = cdb_valid_o && cdb_ready_i;

    branch_rs i_branch_rs (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .issue_valid_i    (issue_valid_i),
        .issue_i          (issue_i),
        .issue_ready_o    (issue_ready_o),
        .ex_valid_o       (ex_valid),
        .ex_data_o        (ex_data),
        .ex_ready_i       (ex_ready),
        .res_valid_i      (res_valid),
        .res_mispredict_i (res_mispredict),
        .wb_valid_o       (wb_valid),
        .wb_data_o        (wb_data),
        .wb_ready_i       (wb_ready),
        .snoop_valid_i    (snoop_valid),
        .snoop_data_i     (cdb_data_o)
    );

    branch_unit i_branch_unit (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .ex_valid_i       (ex_valid),
        .ex_data_i        (ex_data),
        .ex_ready_o       (ex_ready),
        .res_valid_o      (res_valid),
        .res_mispredict_o (res_mispredict)
    );

    cdb_arbiter i_cdb_arbiter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .br_valid_i       (wb_valid),
        .br_data_i        (wb_data),
        .br_ready_o       (wb_ready),
        .ext_valid_i      (ext_valid_i),
        .ext_data_i       (ext_data_i),
        .ext_ready_o      (ext_ready_o),
        .cdb_valid_o      (cdb_valid_o),
        .cdb_data_o       (cdb_data_o),
        .cdb_ready_i      (cdb_ready_i)
    );

endmodule

//--- test/tb_branch_exec.sv
// Directed testbench for the branch execution back end
// Drives issue and external CDB traffic, checks CDB results against a reference model

`timescale 1ns/1ps
`include "branch_macros.svh"

module tb_branch_exec;
    import branch_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int DEPTH           = `BRANCH_RS_DEPTH;

    logic           clk_i = 1'b0;
    logic           rst_n_i, flush_i;
    logic           issue_valid_i, issue_ready_o;
    branch_issue_t  issue_i;
    logic           ext_valid_i, ext_ready_o;
    cdb_data_t      ext_data_i;
    logic           cdb_valid_o, cdb_ready_i;
    cdb_data_t      cdb_data_o;

    logic [31:0]    lfsr_q = 32'h5ab50706;
    cdb_data_t      seen[$];        // Accepted CDB transfers, in order
    cdb_data_t      expected[$];
    int             errors = 0;
    int             tests_failed = 0;

    branch_exec_top i_branch_exec_top (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Inputs only change 2 ns after a rising edge, so the negedge shows the next transfer
    always @(negedge clk_i) begin
        if (rst_n_i && cdb_valid_o && cdb_ready_i) seen.push_back(cdb_data_o);
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers and reference model
    // ------------------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // Taps 32 22 2 1
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic branch_op_e random_op();
        logic [31:0] r;
        r = rand_bits(3);
        return branch_op_e'(r[2:0]);
    endfunction

    // Jump target from the ISA rules
    function automatic logic [31:0] target_of(input branch_issue_t b);
        logic [31:0] t;
        if (b.op == JALR) begin
            t    = b.rs1_value + b.imm;
            t[0] = 1'b0;
        end else begin
            t = b.pc + b.imm;
        end
        return t;
    endfunction

    function automatic logic taken_of(input branch_issue_t b);
        case (b.op)
            BEQ:     return b.rs1_value == b.rs2_value;
            BNE:     return b.rs1_value != b.rs2_value;
            BLT:     return $signed(b.rs1_value) < $signed(b.rs2_value);
            BGE:     return $signed(b.rs1_value) >= $signed(b.rs2_value);
            BLTU:    return b.rs1_value < b.rs2_value;
            BGEU:    return b.rs1_value >= b.rs2_value;
            default: return 1'b1;   // JAL and JALR
        endcase
    endfunction

    function automatic cdb_data_t make_cdb(input rob_idx_t idx, input logic [31:0] value,
                                           input logic exc);
        cdb_data_t d;
        d.rob_idx       = idx;
        d.value         = value;
        d.except_raised = exc;
        return d;
    endfunction

    // Expected CDB record of a branch with its final operand values
    function automatic cdb_data_t result_of(input branch_issue_t b);
        logic mp;
        mp = (taken_of(b) != b.pred_taken) || (taken_of(b) && (target_of(b) != b.pred_target));
        return make_cdb(b.dest_idx, {{(`XLEN-1){1'b0}}, mp}, 1'b0);
    endfunction

    function automatic branch_issue_t random_branch(input branch_op_e op, input rob_idx_t dest);
        branch_issue_t b;
        logic [31:0]   r;
        b           = '0;
        b.op        = op;
        b.rs1_ready = 1'b1;
        b.rs2_ready = 1'b1;
        b.rs1_value = rand_bits(32);
        r           = rand_bits(1);
        b.rs2_value = r[0] ? b.rs1_value : rand_bits(32);   // Equal operands half the time
        r           = rand_bits(12);
        b.imm       = {{20{r[11]}}, r[11:0]};
        r           = rand_bits(30);
        b.pc        = {r[29:0], 2'b00};
        r           = rand_bits(1);
        b.pred_taken = r[0];
        r           = rand_bits(1);
        b.pred_target = r[0] ? target_of(b) : rand_bits(32);
        b.dest_idx  = dest;
        return b;
    endfunction

    // Called 2 ns after an edge, returns 2 ns after the accepting edge
    task automatic drive_issue(input branch_issue_t b);
        issue_i       = b;
        issue_valid_i = 1'b1;
        @(negedge clk_i);
        while (!issue_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        issue_valid_i = 1'b0;
    endtask

    task automatic drive_ext(input cdb_data_t d);
        ext_data_i  = d;
        ext_valid_i = 1'b1;
        @(negedge clk_i);
        while (!ext_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        ext_valid_i = 1'b0;
    endtask

    // Returns 2 ns after the edge that follows the n-th recorded transfer
    task automatic wait_results(input int n);
        @(posedge clk_i);
        while (seen.size() < n) @(posedge clk_i);
        #2;
    endtask

    task automatic check_cdb(input string name, input cdb_data_t got, input cdb_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_results();
        for (int i = 0; i < expected.size(); i++)
            check_cdb($sformatf("cdb_data_o[%0d]", i), seen[i], expected[i]);
        if (seen.size() > expected.size()) begin
            $display("%0d more CDB transfers than expected", seen.size() - expected.size());
            errors++;
        end
        seen.delete();
        expected.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors != errs_before) tests_failed++;
        $display("%-22s %s", name, (errors == errs_before) ? "passed" : "failed");
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic test_all_opcodes();
        int            errs;
        branch_issue_t b;
        errs        = errors;
        cdb_ready_i = 1'b1;
        for (int i = 0; i < 8; i++) begin
            b = random_branch(branch_op_e'(i[2:0]), i[3:0]);
            expected.push_back(result_of(b));
            drive_issue(b);     // Back to back
        end
        wait_results(8);
        compare_results();
        finish_test("opcodes in order", errs);
    endtask

    task automatic test_snooped_operands();
        int            errs;
        branch_issue_t b, model;
        cdb_data_t     bc[4];
        errs              = errors;
        model             = random_branch(BEQ, 4'd9);
        model.rs1_value   = 32'h00c0ffee;  // Values that arrive later on the CDB
        model.rs2_value   = 32'h00c0ffee;
        model.pred_taken  = 1'b1;
        model.pred_target = target_of(model);
        b                 = model;
        b.rs1_ready       = 1'b0;
        b.rs1_idx         = 4'd5;
        b.rs1_value       = 32'h1;          // Stale, must be replaced
        b.rs2_ready       = 1'b0;
        b.rs2_idx         = 4'd6;
        b.rs2_value       = 32'h2;
        bc[0] = make_cdb(4'd5, 32'hdead0001, 1'b1);   // Exception broadcasts are ignored
        bc[1] = make_cdb(4'd6, 32'hbeef0002, 1'b1);
        bc[2] = make_cdb(4'd5, model.rs1_value, 1'b0);
        bc[3] = make_cdb(4'd6, model.rs2_value, 1'b0);
        drive_issue(b);
        repeat (6) begin
            @(negedge clk_i);
            check_bit("cdb_valid_o", cdb_valid_o, 1'b0);
        end
        @(posedge clk_i);
        #2;
        for (int i = 0; i < 4; i++) begin
            expected.push_back(bc[i]);
            drive_ext(bc[i]);
        end
        expected.push_back(result_of(model));
        wait_results(5);
        compare_results();
        finish_test("snooped operands", errs);
    endtask

    task automatic test_back_pressure();
        int            errs;
        branch_issue_t b;
        cdb_data_t     held;
        errs        = errors;
        cdb_ready_i = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            b = random_branch(random_op(), i[3:0] + 4'd4);
            expected.push_back(result_of(b));
            drive_issue(b);
        end
        @(negedge clk_i);
        check_bit("issue_ready_o", issue_ready_o, 1'b0);   // Station full
        while (!cdb_valid_o) @(negedge clk_i);
        held = cdb_data_o;
        repeat (4) begin
            @(negedge clk_i);
            check_bit("cdb_valid_o", cdb_valid_o, 1'b1);
            check_cdb("cdb_data_o", cdb_data_o, held);
        end
        @(posedge clk_i);
        #2;
        cdb_ready_i = 1'b1;
        wait_results(DEPTH);
        compare_results();
        finish_test("back-pressure", errs);
    endtask

    task automatic test_arbitration();
        int            errs;
        branch_issue_t b;
        cdb_data_t     br_res[DEPTH];
        cdb_data_t     ext_rec[DEPTH];
        logic [31:0]   r;
        errs        = errors;
        cdb_ready_i = 1'b0;     // Let branch results pile up first
        for (int i = 0; i < DEPTH; i++) begin
            b         = random_branch(random_op(), i[3:0] + 4'd8);
            br_res[i] = result_of(b);
            drive_issue(b);
            r          = rand_bits(1);
            ext_rec[i] = make_cdb(i[3:0] + 4'd12, rand_bits(32), r[0]);
        end
        @(negedge clk_i);
        while (!cdb_valid_o) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        // Stalled grant stays with the branch station, then the sides alternate
        for (int i = 0; i < DEPTH; i++) begin
            expected.push_back(br_res[i]);
            expected.push_back(ext_rec[i]);
        end
        fork
            for (int i = 0; i < DEPTH; i++) drive_ext(ext_rec[i]);
            begin
                cdb_ready_i = 1'b1;
                @(negedge clk_i);
                check_bit("ext_ready_o", ext_ready_o, 1'b0);   // Producer waits out the held grant
                wait_results(2 * DEPTH);
            end
        join
        compare_results();
        finish_test("arbitration", errs);
    endtask

    task automatic test_flush();
        int            errs;
        branch_issue_t b;
        errs        = errors;
        cdb_ready_i = 1'b0;
        for (int i = 0; i < 3; i++) drive_issue(random_branch(random_op(), i[3:0]));
        @(negedge clk_i);
        while (!cdb_valid_o) @(negedge clk_i);
        @(posedge clk_i);
        #2;
        flush_i = 1'b1;
        @(posedge clk_i);
        #2;
        flush_i     = 1'b0;
        cdb_ready_i = 1'b1;
        repeat (8) begin
            @(negedge clk_i);
            check_bit("cdb_valid_o", cdb_valid_o, 1'b0);
            check_bit("issue_ready_o", issue_ready_o, 1'b1);
        end
        @(posedge clk_i);
        #2;
        if (seen.size() != 0) begin
            $display("Flush left %0d CDB transfers behind", seen.size());
            errors++;
            seen.delete();
        end
        b = random_branch(BNE, 4'd7);   // Fresh branch after the flush
        expected.push_back(result_of(b));
        drive_issue(b);
        wait_results(1);
        compare_results();
        finish_test("flush", errs);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        ext_valid_i   = 1'b0;
        ext_data_i    = '0;
        cdb_ready_i   = 1'b0;
        repeat (5) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        test_all_opcodes();
        test_snooped_operands();
        test_back_pressure();
        test_arbitration();
        test_flush();
        $display("Tests run %0d, failed %0d, check errors %0d", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + 10) @(posedge clk_i);
        $display("Timeout after %0d cycles, the tests did not complete",
                 NUM_TESTS * CYCLES_PER_TEST + 10);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- project.f
+incdir+rtl
rtl/branch_pkg.sv
rtl/branch_unit.sv
rtl/cdb_arbiter.sv
rtl/branch_rs.sv
rtl/branch_exec_top.sv
test/tb_branch_exec.sv

//--- Makefile
# Verilator build and run of the branch execution testbench

SRCS := $(shell grep -v '^+' project.f)
BIN  := obj_dir/Vtb_branch_exec

.PHONY: all run clean

all: run

# Rebuilt only when a source, the header or the file list changes
$(BIN): project.f $(SRCS) rtl/branch_macros.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
		--top-module tb_branch_exec -Mdir obj_dir -o Vtb_branch_exec

# Pass only if the log holds the pass line
run: $(BIN)
	./$(BIN) | tee sim.log
	@grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
